//--- project.f
verilog/blaster_pkg.sv
verilog/keypad_scanner.sv
verilog/tone_generator.sv
verilog/hv_control.sv
verilog/blaster_panel.sv
dv/blaster_panel_asserts.sv
dv/blaster_panel_tb.sv

//--- Bender.yml
package:
  name: blaster_panel

sources:
  # Design
  - files:
      - verilog/blaster_pkg.sv
      - verilog/keypad_scanner.sv
      - verilog/tone_generator.sv
      - verilog/hv_control.sv
      - verilog/blaster_panel.sv

  # Verification
  - target: simulation
    files:
      - dv/blaster_panel_asserts.sv
      - dv/blaster_panel_tb.sv

//--- dv/blaster_panel_tb.sv
`timescale 1ns/1ps

module blaster_panel_tb
	import blaster_pkg::*;
();

	localparam int ROW_DWELL_BITS = 6;
	localparam int PWM_FRAME_BITS = 10;
	localparam int SCAN_FRAME     = 4 << ROW_DWELL_BITS;
	localparam int PWM_FRAME      = 1 << PWM_FRAME_BITS;
	// Half period of the lowest tone in cycles
	localparam int MAX_HALF       = 'h2CCB;
	localparam int KEY_LIMIT      = 2 * SCAN_FRAME + 8;
	localparam int N_TESTS        = 21;
	localparam longint WATCHDOG_NS =
		longint'(N_TESTS) * (4 * SCAN_FRAME + 4 * MAX_HALF) * 10 * 2;

	// Pad bit of each keypad row and column
	localparam int ROW_PAD [4] = '{1, 6, 5, 3};
	localparam int COL_PAD [3] = '{4, 0, 2};

	typedef struct packed {
		logic        press;
		logic [1:0]  row;
		logic [1:0]  col;
		logic        fire;
		logic        done;
		logic        cont_n;
		logic [2:0]  iset;
		logic [3:0]  code;
		logic [15:0] half;
		logic [7:0]  pulse;
		logic        charge;
		logic        dump;
		logic        arm_n;
		logic        cont_led_n;
	} vector_t;

	logic       clk;
	logic       reset;
	logic       fire_button;
	logic       lt3420_done;
	logic       cont_n;
	logic [2:0] iset;
	pad_vec_t   keypad_sense = '1;
	pad_vec_t   keypad_drive;
	logic       speaker;
	logic       speaker_n;
	hv_cmd_t    hv;
	logic       arm_led_n;
	logic       cont_led_n;

	// Keypad model state
	logic       press_on = 1'b0;
	logic [1:0] press_row = '0;
	logic [1:0] press_col = '0;

	vector_t     vectors [N_TESTS];
	string       test_name [N_TESTS];
	int          order [N_TESTS];
	int          fill_idx = 0;
	logic [31:0] rng_state = 32'd31126;
	string       cur_name;
	int          test_errors;
	int          pass_count = 0;
	int          fail_count = 0;

	blaster_panel #(
		.ROW_DWELL_BITS(ROW_DWELL_BITS),
		.PWM_FRAME_BITS(PWM_FRAME_BITS)
	) blaster_panel_i (
		.clk         (clk),
		.reset       (reset),
		.fire_button (fire_button),
		.lt3420_done (lt3420_done),
		.cont_n      (cont_n),
		.iset        (iset),
		.keypad_sense(keypad_sense),
		.keypad_drive(keypad_drive),
		.speaker     (speaker),
		.speaker_n   (speaker_n),
		.hv          (hv),
		.arm_led_n   (arm_led_n),
		.cont_led_n  (cont_led_n)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////
	// Keypad model
	////////////////////
	function automatic pad_vec_t sense_for(input pad_vec_t drive, input logic on,
			input logic [1:0] row, input logic [1:0] col);
		pad_vec_t s;
		s = '1;
		// Closed switch pulls its column low while its row is driven low
		if (on && drive[ROW_PAD[row]] == 1'b0) begin
			s[COL_PAD[col]] = 1'b0;
		end
		return s;
	endfunction

	always @(negedge clk) begin
		keypad_sense <= sense_for(keypad_drive, press_on, press_row, press_col);
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic add_test(input string name, input int press, input int row, input int col,
			input int fire, input int done, input int cnt_n, input logic [2:0] sw,
			input int code, input int half, input int pulse, input int charge,
			input int dump, input int arm_n, input int cont_led);
		test_name[fill_idx] = name;
		vectors[fill_idx] = '{press[0], row[1:0], col[1:0], fire[0], done[0], cnt_n[0],
			sw, code[3:0], half[15:0], pulse[7:0], charge[0], dump[0], arm_n[0],
			cont_led[0]};
		fill_idx++;
	endtask

	////////////////////
	// Stimulus table
	////////////////////
	task automatic load_table();
		// name, press row col, fire done cont_n iset, code half pulse, charge dump arm cont
		add_test("key 3 r0 c0", 1, 0, 0, 0, 0, 1, 3'b111, 'h3, 'h238E, 0, 0, 0, 1, 1);
		add_test("key 2 r0 c1", 1, 0, 1, 0, 0, 1, 3'b111, 'h2, 'h27E8, 0, 0, 0, 1, 1);
		add_test("key 1 r0 c2", 1, 0, 2, 0, 0, 1, 3'b111, 'h1, 'h2CCB, 0, 0, 0, 1, 1);
		add_test("key 6 r1 c0", 1, 1, 0, 0, 0, 1, 3'b111, 'h6, 'h1AA3, 0, 0, 0, 1, 1);
		add_test("key 5 r1 c1", 1, 1, 1, 0, 0, 1, 3'b111, 'h5, 'h1DE6, 0, 0, 0, 1, 1);
		add_test("key 4 r1 c2", 1, 1, 2, 0, 0, 1, 3'b111, 'h4, 'h218F, 0, 0, 0, 1, 1);
		add_test("key 9 r2 c0", 1, 2, 0, 0, 0, 1, 3'b111, 'h9, 0, 128, 0, 0, 1, 1);
		add_test("key 8 r2 c1", 1, 2, 1, 0, 0, 1, 3'b111, 'h8, 'h1666, 0, 0, 0, 1, 1);
		add_test("key 7 r2 c2", 1, 2, 2, 0, 0, 1, 3'b111, 'h7, 'h17BB, 0, 0, 0, 1, 1);
		add_test("key B r3 c0", 1, 3, 0, 0, 0, 1, 3'b111, 'hB, 0, 0, 0, 1, 1, 1);
		add_test("key 0 r3 c1", 1, 3, 1, 0, 0, 1, 3'b111, 'h0, 0, 64, 0, 0, 1, 1);
		add_test("key A r3 c2", 1, 3, 2, 0, 0, 1, 3'b111, 'hA, 0, 0, 1, 0, 1, 1);
		add_test("idle", 0, 0, 0, 0, 0, 1, 3'b111, 0, 0, 0, 0, 0, 1, 1);
		add_test("fire button", 0, 0, 0, 1, 0, 1, 3'b111, 0, 0, 64, 0, 0, 0, 1);
		add_test("lt3420 done", 0, 0, 0, 0, 1, 1, 3'b111, 0, 0, 0, 0, 0, 0, 1);
		add_test("continuity", 0, 0, 0, 0, 0, 0, 3'b111, 0, 0, 0, 0, 0, 1, 0);
		add_test("charge switch", 0, 0, 0, 0, 0, 1, 3'b011, 0, 0, 0, 1, 0, 1, 1);
		add_test("dump switch", 0, 0, 0, 0, 0, 0, 3'b101, 0, 0, 0, 0, 1, 1, 1);
		add_test("both switches", 0, 0, 0, 0, 0, 0, 3'b000, 0, 0, 0, 1, 1, 1, 1);
		add_test("fire key, charge sw", 1, 3, 1, 0, 0, 1, 3'b011, 'h0, 0, 64, 1, 0, 1, 1);
		add_test("charge key, dump sw", 1, 3, 2, 0, 0, 1, 3'b101, 'hA, 0, 0, 1, 1, 1, 1);
	endtask

	// Fisher-Yates over the test indices
	task automatic shuffle_order();
		int j;
		int tmp;
		for (int i = 0; i < N_TESTS; i++) begin
			order[i] = i;
		end
		for (int i = N_TESTS - 1; i > 0; i--) begin
			rng_state = xorshift32(rng_state);
			j = int'(rng_state % (i + 1));
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
	endtask

	task automatic value_mismatch(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", cur_name, what, expected, actual);
		test_errors++;
	endtask

	task automatic failure_note(input string what);
		$display("[ERROR] %s: %s", cur_name, what);
		test_errors++;
	endtask

	////////////////////
	// Drive and observe
	////////////////////
	task automatic apply_inputs(input vector_t v);
		@(posedge clk);
		press_on  <= v.press;
		press_row <= v.row;
		press_col <= v.col;
		@(negedge clk);
		fire_button = v.fire;
		lt3420_done = v.done;
		cont_n      = v.cont_n;
		iset        = v.iset;
	endtask

	task automatic release_inputs();
		@(posedge clk);
		press_on <= 1'b0;
		@(negedge clk);
		fire_button = 1'b0;
		lt3420_done = 1'b0;
		cont_n      = 1'b1;
		iset        = 3'b111;
	endtask

	// Key shows up, or clears, within two scan frames
	task automatic wait_for_key(input key_t want);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (blaster_panel_i.key !== want && cycles < KEY_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (blaster_panel_i.key !== want) begin
			value_mismatch("key", want, blaster_panel_i.key);
		end
	endtask

	task automatic compare_levels(input vector_t v);
		if (hv.charge !== v.charge) value_mismatch("charge", v.charge, hv.charge);
		if (hv.dump !== v.dump) value_mismatch("dump", v.dump, hv.dump);
		if (arm_led_n !== v.arm_n) value_mismatch("arm_led_n", v.arm_n, arm_led_n);
		if (cont_led_n !== v.cont_led_n) value_mismatch("cont_led_n", v.cont_led_n, cont_led_n);
	endtask

	// One row pad low at a time, and every row within a scan frame
	task automatic check_drive();
		logic [3:0] seen;
		logic       valid;
		seen = '0;
		repeat (SCAN_FRAME) begin
			@(negedge clk);
			valid = 1'b0;
			for (int r = 0; r < 4; r++) begin
				if (keypad_drive === ~(pad_vec_t'(1) << ROW_PAD[r])) begin
					valid   = 1'b1;
					seen[r] = 1'b1;
				end
			end
			if (!valid) begin
				failure_note("keypad drive is not exactly one row driven low");
				return;
			end
		end
		if (seen !== 4'hF) failure_note("keypad scan did not drive every row in a frame");
	endtask

	// First edge may close an old count, so only later gaps are compared
	task automatic measure_tone(input int half);
		int   gap;
		int   edges;
		int   waited;
		logic last;
		gap    = 0;
		edges  = 0;
		waited = 0;
		last   = speaker;
		while (edges < 3 && waited < 4 * MAX_HALF + 16) begin
			@(negedge clk);
			waited++;
			gap++;
			if (speaker !== last) begin
				if (edges > 0 && gap != half) value_mismatch("speaker half period", half, gap);
				if (speaker_n !== ~speaker) failure_note("speaker_n does not mirror speaker");
				edges++;
				gap  = 0;
				last = speaker;
			end
		end
		if (edges < 3) failure_note("speaker stopped toggling with a tone key held");
	endtask

	task automatic watch_silence();
		int n;
		logic bad;
		n   = 0;
		bad = 1'b0;
		// Let a count left from an earlier tone run out
		repeat (MAX_HALF + 2) @(negedge clk);
		while (n < MAX_HALF && !bad) begin
			@(negedge clk);
			n++;
			bad = (speaker !== 1'b0) || (speaker_n !== 1'b1);
		end
		if (bad) failure_note("speaker moved with no tone key held");
	endtask

	task automatic measure_pulse(input int width);
		int   waited;
		int   high;
		int   period;
		logic last;
		logic rose;
		waited = 0;
		rose   = 1'b0;
		last   = hv.pwm;
		// Start on a real rising edge so no partial pulse is measured
		while (!rose && waited < 2 * PWM_FRAME) begin
			@(negedge clk);
			waited++;
			rose = hv.pwm && !last;
			last = hv.pwm;
		end
		if (!rose) begin
			failure_note("no pwm pulse while a pulse was requested");
			return;
		end
		high = 1;
		@(negedge clk);
		while (hv.pwm === 1'b1 && high < 2 * PWM_FRAME) begin
			high++;
			@(negedge clk);
		end
		period = high;
		while (hv.pwm === 1'b0 && period < 2 * PWM_FRAME) begin
			period++;
			@(negedge clk);
		end
		if (high != width) value_mismatch("pwm pulse width", width, high);
		if (period != PWM_FRAME) value_mismatch("pwm pulse spacing", PWM_FRAME, period);
	endtask

	task automatic watch_no_pulse();
		int n;
		logic bad;
		n   = 0;
		bad = 1'b0;
		while (n < PWM_FRAME && !bad) begin
			@(negedge clk);
			n++;
			bad = (hv.pwm !== 1'b0);
		end
		if (bad) failure_note("pwm pulsed with no pulse requested");
	endtask

	task automatic run_test(input int idx);
		vector_t v;
		key_t    want;
		v            = vectors[idx];
		cur_name     = test_name[idx];
		test_errors  = 0;
		want.pressed = v.press;
		want.code    = v.press ? v.code : 4'h0;
		apply_inputs(v);
		wait_for_key(want);
		compare_levels(v);
		check_drive();
		if (v.half != 0) measure_tone(v.half);
		else watch_silence();
		if (v.pulse != 0) measure_pulse(v.pulse);
		else watch_no_pulse();
		// Release has to clear the key again
		release_inputs();
		wait_for_key('0);
		if (test_errors == 0) begin
			pass_count++;
			$display("[PASS] %s", cur_name);
		end else begin
			fail_count++;
			$display("[FAIL] %s with %0d error(s)", cur_name, test_errors);
		end
	endtask

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired, the tests ran longer than their time budget");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin : main_seq
		int i;
		reset       = 1'b1;
		fire_button = 1'b0;
		lt3420_done = 1'b0;
		cont_n      = 1'b1;
		iset        = 3'b111;
		load_table();
		shuffle_order();
		repeat (16) @(negedge clk);
		reset = 1'b0;
		for (i = 0; i < N_TESTS; i++) begin
			run_test(order[i]);
		end
		$display("Tests run: %0d, passed: %0d, failed: %0d", N_TESTS, pass_count, fail_count);
		if (fail_count == 0 && pass_count == N_TESTS) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- dv/blaster_panel_asserts.sv
`timescale 1ns/1ps

module blaster_panel_asserts
	import blaster_pkg::*;
#(
	parameter int LONG_PULSE_BITS = 7
) (
	input logic    clk,
	input logic    reset,
	input logic    speaker,
	input logic    speaker_n,
	input hv_cmd_t hv,
	input key_t    key
);

	localparam int PULSE_LIMIT = 1 << LONG_PULSE_BITS;

	// Cycles pwm has already been high, saturating
	logic [LONG_PULSE_BITS+1:0] pwm_run;

	always_ff @(posedge clk) begin
		if (reset) begin
			pwm_run <= '0;
		end else if (!hv.pwm) begin
			pwm_run <= '0;
		end else if (pwm_run != '1) begin
			pwm_run <= pwm_run + 1'b1;
		end
	end

	speaker_pair: assert property (@(posedge clk) disable iff (reset)
		speaker_n == ~speaker)
		else $error("speaker_n is not the inverse of speaker");

	pwm_width: assert property (@(posedge clk) disable iff (reset)
		hv.pwm |-> (pwm_run < PULSE_LIMIT))
		else $error("pwm pulse longer than the long pulse width");

	// Codes above B are never produced
	key_range: assert property (@(posedge clk) disable iff (reset)
		key.pressed |-> (key.code <= KEY_DUMP))
		else $error("key code out of range while pressed");

endmodule

bind blaster_panel blaster_panel_asserts #(
	.LONG_PULSE_BITS(LONG_PULSE_BITS)
) blaster_panel_asserts_i (
	.clk      (clk),
	.reset    (reset),
	.speaker  (speaker),
	.speaker_n(speaker_n),
	.hv       (hv),
	.key      (key)
);

//--- verilog/blaster_panel.sv
`timescale 1ns/1ps

module blaster_panel
	import blaster_pkg::*;
#(
	parameter int ROW_DWELL_BITS   = 10,
	parameter int PWM_FRAME_BITS   = 16,
	parameter int SHORT_PULSE_BITS = 6,
	parameter int LONG_PULSE_BITS  = 7
) (
	input  logic       clk,
	input  logic       reset,

	// Buttons, switches and charger status
	input  logic       fire_button,
	input  logic       lt3420_done,
	input  logic       cont_n,
	input  logic [2:0] iset,

	// Keypad
	input  pad_vec_t   keypad_sense,
	output pad_vec_t   keypad_drive,

	// Speaker pair
	output logic       speaker,
	output logic       speaker_n,

	output hv_cmd_t    hv,
	output logic       arm_led_n,
	output logic       cont_led_n
);

	key_t key;

	keypad_scanner #(
		.ROW_DWELL_BITS(ROW_DWELL_BITS)
	) keypad_scanner_i (
		.clk         (clk),
		.reset       (reset),
		.keypad_sense(keypad_sense),
		.keypad_drive(keypad_drive),
		.key         (key)
	);

	// Both consumers see the same registered key
	tone_generator tone_generator_i (
		.clk      (clk),
		.reset    (reset),
		.key      (key),
		.speaker  (speaker),
		.speaker_n(speaker_n)
	);

	hv_control #(
		.PWM_FRAME_BITS  (PWM_FRAME_BITS),
		.SHORT_PULSE_BITS(SHORT_PULSE_BITS),
		.LONG_PULSE_BITS (LONG_PULSE_BITS)
	) hv_control_i (
		.clk        (clk),
		.reset      (reset),
		.key        (key),
		.fire_button(fire_button),
		.lt3420_done(lt3420_done),
		.cont_n     (cont_n),
		.iset       (iset),
		.hv         (hv),
		.arm_led_n  (arm_led_n),
		.cont_led_n (cont_led_n)
	);

endmodule

//--- verilog/hv_control.sv
`timescale 1ns/1ps

module hv_control
	import blaster_pkg::*;
#(
	parameter int PWM_FRAME_BITS   = 16,
	parameter int SHORT_PULSE_BITS = 6,
	parameter int LONG_PULSE_BITS  = 7
) (
	input  logic       clk,
	input  logic       reset,
	input  key_t       key,
	input  logic       fire_button,
	input  logic       lt3420_done,
	input  logic       cont_n,
	input  logic [2:0] iset,
	output hv_cmd_t    hv,
	output logic       arm_led_n,
	output logic       cont_led_n
);

	logic [PWM_FRAME_BITS-1:0] frame_cnt;
	logic                      short_win;
	logic                      long_win;
	logic                      fire_req;
	logic                      long_req;
	logic                      charge_key;
	logic                      dump_key;

	////////////////////
	// PWM timebase
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			frame_cnt <= '0;
		end else begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// Pulse windows at the start of every frame
	assign short_win = (frame_cnt[PWM_FRAME_BITS-1:SHORT_PULSE_BITS] == '0);
	assign long_win  = (frame_cnt[PWM_FRAME_BITS-1:LONG_PULSE_BITS] == '0);

	// Key decode, code 0 is only the fire key while pressed
	assign fire_req   = fire_button || (key.pressed && key.code == KEY_FIRE);
	assign long_req   = key.pressed && (key.code == KEY_LONG_PULSE);
	assign charge_key = key.pressed && (key.code == KEY_CHARGE);
	assign dump_key   = key.pressed && (key.code == KEY_DUMP);

	assign hv.pwm = (fire_req && short_win) || (long_req && long_win);

	// iset switches are active low
	assign hv.charge = ~iset[2] | charge_key;
	assign hv.dump   = ~iset[1] | dump_key;

	////////////////////
	// LEDs, active low
	////////////////////
	assign arm_led_n = ~(fire_button | lt3420_done);

	// Continuity shown only while the dump switch is open
	assign cont_led_n = ~(~cont_n & iset[1]);

endmodule

//--- verilog/tone_generator.sv
`timescale 1ns/1ps

module tone_generator
	import blaster_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  key_t key,
	output logic speaker,
	output logic speaker_n
);

	tone_div_t  tone_cnt;
	tone_div_t  reload;
	logic [2:0] tone_idx;
	logic       is_tone;
	logic       spk_toggle;
	logic       spk_en;

	// Tone keys 1 to 8 map onto table entries 0 to 7
	assign is_tone  = key.pressed && (key.code >= KEY_TONE_1) && (key.code <= KEY_TONE_8);
	assign tone_idx = key.code[2:0] - 3'd1;
	assign reload   = is_tone ? TONE_DIV[tone_idx] : '0;

	////////////////////
	// Half-period counter
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			tone_cnt   <= '0;
			spk_toggle <= 1'b0;
			spk_en     <= 1'b0;
		end else begin
			if (tone_cnt == '0) begin
				// Key is looked at only here, so a new tone starts on a clean edge
				spk_toggle <= ~spk_toggle;
				spk_en     <= is_tone;
				tone_cnt   <= reload;
			end else begin
				tone_cnt <= tone_cnt - 1'b1;
			end
		end
	end

	// Differential drive doubles the swing at the speaker
	assign speaker   = spk_toggle & spk_en;
	assign speaker_n = ~speaker;

endmodule

//--- verilog/keypad_scanner.sv
`timescale 1ns/1ps

module keypad_scanner
	import blaster_pkg::*;
#(
	parameter int ROW_DWELL_BITS = 10
) (
	input  logic     clk,
	input  logic     reset,
	input  pad_vec_t keypad_sense,
	output pad_vec_t keypad_drive,
	output key_t     key
);

	localparam int SCAN_BITS = ROW_DWELL_BITS + 2;
	localparam logic [ROW_DWELL_BITS-1:0] SAMPLE_AT =
		ROW_DWELL_BITS'((1 << ROW_DWELL_BITS) - SAMPLE_LEAD);

	logic [SCAN_BITS-1:0]      scan_cnt;
	logic [1:0]                scan_row;
	logic [ROW_DWELL_BITS-1:0] dwell_pos;
	logic                      frame_start;
	logic                      frame_end;
	logic                      sample_now;
	logic [2:0]                col_low;
	logic [2:0]                col_pick;
	pad_vec_t                  drive_next;
	logic                      press_flag;
	logic [1:0]                hit_row;
	logic [2:0]                hit_col;
	key_code_t                 hit_code;

	// Upper two bits pick the row, the rest is the dwell position
	assign scan_row    = scan_cnt[SCAN_BITS-1 -: 2];
	assign dwell_pos   = scan_cnt[ROW_DWELL_BITS-1:0];
	assign frame_start = (scan_cnt == '0);
	assign frame_end   = (scan_cnt == '1);
	assign sample_now  = (dwell_pos == SAMPLE_AT);

	always_comb begin
		drive_next = '1;
		for (int r = 0; r < 4; r++) begin
			if (scan_row == 2'(r)) begin
				drive_next[ROW_PIN[r]] = 1'b0;
			end
		end
	end

	// Columns sense low on a press
	always_comb begin
		for (int c = 0; c < 3; c++) begin
			col_low[c] = ~keypad_sense[COL_PIN[c]];
		end
	end

	// Lowest column wins when several read low
	always_comb begin
		col_pick = 3'b000;
		if (col_low[0]) begin
			col_pick = 3'b001;
		end else if (col_low[1]) begin
			col_pick = 3'b010;
		end else if (col_low[2]) begin
			col_pick = 3'b100;
		end
	end

	////////////////////
	// Key map
	////////////////////
	always_comb begin
		case (hit_row)
			2'd0: hit_code = hit_col[0] ? KEY_TONE_3 : hit_col[1] ? KEY_TONE_2 : KEY_TONE_1;
			2'd1: hit_code = hit_col[0] ? KEY_TONE_6 : hit_col[1] ? KEY_TONE_5 : KEY_TONE_4;
			2'd2: hit_code = hit_col[0] ? KEY_LONG_PULSE : hit_col[1] ? KEY_TONE_8 : KEY_TONE_7;
			default: hit_code = hit_col[0] ? KEY_DUMP : hit_col[1] ? KEY_FIRE : KEY_CHARGE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			scan_cnt     <= '0;
			keypad_drive <= '0;
			press_flag   <= 1'b0;
			hit_row      <= '0;
			hit_col      <= '0;
			key          <= '0;
		end else begin
			scan_cnt     <= scan_cnt + 1'b1;
			keypad_drive <= drive_next;

			if (frame_start) begin
				press_flag <= 1'b0;
			end else if (frame_end && !press_flag) begin
				// Nothing seen this frame, key released
				hit_row <= '0;
				hit_col <= '0;
			end else if (sample_now && (|col_low)) begin
				press_flag <= 1'b1;
				hit_row    <= scan_row;
				hit_col    <= col_pick;
			end

			key.pressed <= |hit_col;
			key.code    <= (|hit_col) ? hit_code : '0;
		end
	end

endmodule

//--- verilog/blaster_pkg.sv
package blaster_pkg;

	////////////////////
	// Vector types
	////////////////////

	// Keypad pads, one drive bus and one sense bus
	typedef logic [6:0] pad_vec_t;

	// Tone half-period reload
	typedef logic [15:0] tone_div_t;

	typedef logic [3:0] key_code_t;

	////////////////////
	// Structs
	////////////////////

	// Scanner result, code is 0 with no key held
	typedef struct packed {
		logic      pressed;
		key_code_t code;
	} key_t;

	typedef struct packed {
		logic charge;
		logic dump;
		logic pwm;
	} hv_cmd_t;

	////////////////////
	// Key codes
	////////////////////

	localparam key_code_t KEY_FIRE       = 4'h0;
	localparam key_code_t KEY_TONE_1     = 4'h1;
	localparam key_code_t KEY_TONE_2     = 4'h2;
	localparam key_code_t KEY_TONE_3     = 4'h3;
	localparam key_code_t KEY_TONE_4     = 4'h4;
	localparam key_code_t KEY_TONE_5     = 4'h5;
	localparam key_code_t KEY_TONE_6     = 4'h6;
	localparam key_code_t KEY_TONE_7     = 4'h7;
	localparam key_code_t KEY_TONE_8     = 4'h8;
	localparam key_code_t KEY_LONG_PULSE = 4'h9;
	localparam key_code_t KEY_CHARGE     = 4'hA;
	localparam key_code_t KEY_DUMP       = 4'hB;

	// Divisors for tone keys 1 to 8, lowest pitch first
	localparam tone_div_t TONE_DIV [8] = '{
		16'h2CCA, 16'h27E7, 16'h238D, 16'h218E,
		16'h1DE5, 16'h1AA2, 16'h17BA, 16'h1665
	};

	// Column sample taken this many cycles before the row ends
	localparam int SAMPLE_LEAD = 16;

	// Pad bit of each row and each column
	localparam int ROW_PIN [4] = '{1, 6, 5, 3};
	localparam int COL_PIN [3] = '{4, 0, 2};

endpackage
